// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := frontend_tb
FILELIST := verilog.f
OBJDIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass message"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out=$$(./$(OBJDIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== bench/frontend_checker.sv ====
/* Front end port checker
   Reset state, valid encoding, pop bound and window alignment of the fetch address */

`timescale 1ns/1ps

module frontend_checker
(
   input logic                     clk,
   input logic                     arst_n,
   input logic [fetch_pkg::FW-1:0] id_valid,
   input logic [fetch_pkg::P_FW:0] id_pop_cnt,
   input logic [fetch_pkg::AW-1:0] imem_addr
);
   import fetch_pkg::*;

   // Queue is empty while reset is held
   a_reset_empty: assert property (@(posedge clk) !arst_n |-> (id_valid == '0))
      else $error("id_valid not zero during reset");

   // Thermometer code toward decode
   a_valid_thermo: assert property (@(posedge clk) disable iff (!arst_n)
      id_valid[1] |-> id_valid[0])
      else $error("id_valid bit 1 set without bit 0");

   a_pop_bound: assert property (@(posedge clk) disable iff (!arst_n)
      id_pop_cnt <= (P_FW+1)'($countones(id_valid)))
      else $error("id_pop_cnt above the number of valid entries");

   // Fetch address always starts a window
   a_addr_aligned: assert property (@(posedge clk)
      imem_addr[P_FW+P_INSN_LEN-1:0] == '0)
      else $error("imem_addr not aligned to the fetch window");

endmodule

bind frontend frontend_checker u_checker
(
   .clk        (clk),
   .arst_n     (arst_n),
   .id_valid   (id_valid),
   .id_pop_cnt (id_pop_cnt),
   .imem_addr  (imem_addr)
);

// ==== bench/frontend_tb.sv ====
/* Fetch front end testbench
   Directed tests with a random-pop decode model and an in-order scoreboard */

`timescale 1ns/1ps

module frontend_tb;
   import fetch_pkg::*;

   localparam int  STALL_LIMIT = 64;
   localparam int  TLB_N = 1 << P_TLB_SETS;
   localparam pc_t BR_PC = 30'h80;

   logic          clk;
   logic          arst_n;
   logic          flush;
   pc_t           flush_tgt;
   logic [FW-1:0] id_valid;
   fetch_slot_t   id_slot [FW];
   logic [P_FW:0] id_pop_cnt;
   bpu_wb_t       bpu_wb;
   logic          psr_imme;
   tlb_msr_t      tlb_msr;
   logic [AW-1:0] imem_addr;
   insn_t         imem_rdata [FW];

   // Reference TLB contents
   logic             ref_v [TLB_N];
   logic [VPN_W-1:0] ref_vpn [TLB_N];
   logic             ref_x [TLB_N];
   logic [VPN_W-1:0] ref_ppn [TLB_N];

   // Expected stream, oldest first
   pc_t      exp_pc_q [$];
   logic     exp_tk_q [$];
   bpu_upd_t br_upd;
   int       checks;
   int       errors;

   frontend dut_i
   (
      .clk        (clk),
      .arst_n     (arst_n),
      .flush      (flush),
      .flush_tgt  (flush_tgt),
      .id_valid   (id_valid),
      .id_slot    (id_slot),
      .id_pop_cnt (id_pop_cnt),
      .bpu_wb     (bpu_wb),
      .psr_imme   (psr_imme),
      .tlb_msr    (tlb_msr),
      .imem_addr  (imem_addr),
      .imem_rdata (imem_rdata)
   );

   function automatic insn_t mem_word(logic [AW-1:0] a);
      return a ^ 32'h5a5a_0000;
   endfunction

   // Asynchronous instruction memory
   for (genvar j = 0; j < FW; j++)
   begin : g_imem
      assign imem_rdata[j] = mem_word(imem_addr + AW'(j << P_INSN_LEN));
   end

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic fetch_slot_t expect_slot(pc_t pc, logic taken);
      fetch_slot_t           s;
      logic [VPN_W-1:0]      vpn;
      logic [P_TLB_SETS-1:0] idx;
      logic [AW-1:0]         pa;
      s = '0;
      s.pc = pc;
      s.upd.taken = taken;
      vpn = pc[PC_W-1 -: VPN_W];
      idx = vpn[P_TLB_SETS-1:0];
      pa = {pc, {P_INSN_LEN{1'b0}}};
      if (psr_imme)
      begin
         if (!ref_v[idx] || (ref_vpn[idx] != vpn))
            s.exc.itm = 1'b1;
         else if (!ref_x[idx])
            s.exc.ipf = 1'b1;
         else
            pa = {ref_ppn[idx], pc[P_PAGE-P_INSN_LEN-1:0], {P_INSN_LEN{1'b0}}};
      end
      // Faulting slots carry no instruction
      if (s.exc == '0)
         s.insn = mem_word(pa);
      return s;
   endfunction

   task automatic finish_run();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   endtask

   task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
      end
   endtask

   task automatic expect_seq(pc_t first, int n);
      for (int i = 0; i < n; i++)
      begin
         exp_pc_q.push_back(first + PC_W'(i));
         exp_tk_q.push_back(1'b0);
      end
   endtask

   task automatic expect_one(pc_t pc, logic taken);
      exp_pc_q.push_back(pc);
      exp_tk_q.push_back(taken);
   endtask

   // Decode model: random pops of 0 to 2 until every expected slot is seen
   task automatic drain();
      int          idle;
      int          avail;
      int          n;
      pc_t         pc;
      logic        tk;
      fetch_slot_t exp;
      fetch_slot_t got;
      idle = 0;
      while (exp_pc_q.size() > 0)
      begin
         @(negedge clk);
         avail = $countones(id_valid);
         n = $urandom_range(2, 0);
         if (n > avail)
            n = avail;
         if (n > exp_pc_q.size())
            n = exp_pc_q.size();
         for (int k = 0; k < n; k++)
         begin
            pc = exp_pc_q.pop_front();
            tk = exp_tk_q.pop_front();
            exp = expect_slot(pc, tk);
            got = id_slot[k];
            check_value("id_slot.pc", got.pc, exp.pc);
            check_value("id_slot.insn", got.insn, exp.insn);
            check_value("id_slot.exc", got.exc, exp.exc);
            check_value("id_slot.upd.taken", got.upd.taken, exp.upd.taken);
            if (got.pc == BR_PC)
               br_upd = got.upd;
         end
         id_pop_cnt = (P_FW+1)'(n);
         idle = (avail == 0) ? idle + 1 : 0;
         if (idle > STALL_LIMIT)
         begin
            $display("Timeout: no slot reached decode for pc 0x%0h in %0d cycles",
                     exp_pc_q[0], STALL_LIMIT);
            errors++;
            finish_run();
         end
      end
      @(negedge clk);
      id_pop_cnt = '0;
   endtask

   task automatic flush_to(pc_t tgt);
      @(negedge clk);
      flush = 1'b1;
      flush_tgt = tgt;
      @(negedge clk);
      flush = 1'b0;
   endtask

   task automatic send_wb(pc_t pc, logic taken, pc_t npc, bpu_upd_t upd);
      @(negedge clk);
      bpu_wb.valid = 1'b1;
      bpu_wb.is_bcc = 1'b1;
      bpu_wb.taken = taken;
      bpu_wb.pc = pc;
      bpu_wb.npc_act = npc;
      bpu_wb.upd = upd;
      @(negedge clk);
      bpu_wb = '0;
   endtask

   task automatic tlb_write(logic [P_TLB_SETS-1:0] idx, logic [VPN_W-1:0] vpn,
                            logic [VPN_W-1:0] ppn, logic x);
      @(negedge clk);
      tlb_msr = '0;
      tlb_msr.tlbl_we = 1'b1;
      tlb_msr.idx = idx;
      tlb_msr.data = {vpn, {(P_PAGE-1){1'b0}}, 1'b1};
      @(negedge clk);
      tlb_msr.tlbl_we = 1'b0;
      tlb_msr.tlbh_we = 1'b1;
      tlb_msr.data = {ppn, {(P_PAGE-1){1'b0}}, x};
      @(negedge clk);
      tlb_msr = '0;
      ref_v[idx] = 1'b1;
      ref_vpn[idx] = vpn;
      ref_x[idx] = x;
      ref_ppn[idx] = ppn;
   endtask

   task automatic test_sequential();
      expect_seq('0, 40);
      drain();
   endtask

   task automatic test_flush_unaligned();
      flush_to(30'h41);
      expect_seq(30'h41, 3);
      drain();
   endtask

   task automatic test_taken_branch();
      flush_to(BR_PC - 2);
      expect_seq(BR_PC - 2, 3);
      drain();
      send_wb(BR_PC, 1'b1, 30'h100, br_upd);
      send_wb(BR_PC, 1'b1, 30'h100, br_upd);
      flush_to(BR_PC - 2);
      expect_seq(BR_PC - 2, 2);
      expect_one(BR_PC, 1'b1);
      expect_seq(30'h100, 2);
      drain();
      // One step up from weak not-taken
      check_value("id_slot.upd.ctr", br_upd.ctr, CTR_WEAK_T);
   endtask

   task automatic test_counter_decay();
      send_wb(BR_PC, 1'b0, BR_PC + 1, br_upd);
      send_wb(BR_PC, 1'b0, BR_PC + 1, br_upd);
      flush_to(BR_PC - 2);
      expect_seq(BR_PC - 2, 5);
      drain();
      check_value("id_slot.upd.ctr", br_upd.ctr, CTR_WEAK_NT);
   endtask

   task automatic test_translation();
      tlb_write(2'd3, 19'd3, 19'd9, 1'b1);
      tlb_write(2'd2, 19'd6, 19'd10, 1'b0);
      @(negedge clk);
      psr_imme = 1'b1;
      flush_to(30'h1805);
      expect_seq(30'h1805, 6);
      drain();
      // Page 7 shares index 3 with page 3, so the tag misses
      flush_to(30'h3800);
      expect_seq(30'h3800, 4);
      drain();
      flush_to(30'h3000);
      expect_seq(30'h3000, 4);
      drain();
      @(negedge clk);
      psr_imme = 1'b0;
   endtask

   initial
   begin
      void'($urandom(32'hc0b2));
      checks = 0;
      errors = 0;
      arst_n = 1'b0;
      flush = 1'b0;
      flush_tgt = '0;
      id_pop_cnt = '0;
      bpu_wb = '0;
      psr_imme = 1'b0;
      tlb_msr = '0;
      br_upd = '0;
      for (int i = 0; i < TLB_N; i++)
      begin
         ref_v[i] = 1'b0;
         ref_vpn[i] = '0;
         ref_x[i] = 1'b0;
         ref_ppn[i] = '0;
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      test_sequential();
      test_flush_unaligned();
      test_taken_branch();
      test_counter_decay();
      test_translation();
      finish_run();
   end

endmodule

// ==== hw/branch_predictor.sv ====
/* Branch predictor
   Direct-mapped target buffer with 2-bit counters, one lookup per window slot */

`timescale 1ns/1ps

module branch_predictor
(
   input  logic                clk,
   input  logic                arst_n,
   input  logic                re,
   input  fetch_pkg::pc_t      fetch_pc,
   input  fetch_pkg::bpu_wb_t  bpu_wb,
   output fetch_pkg::pc_t      pred_npc [fetch_pkg::FW],
   output fetch_pkg::bpu_upd_t pred_upd [fetch_pkg::FW]
);
   import fetch_pkg::*;

   logic [(1<<P_BTB_NUM)-1:0] btb_v;
   logic [PC_W-P_BTB_NUM-1:0] btb_tag [1<<P_BTB_NUM];
   pc_t                       btb_tgt [1<<P_BTB_NUM];
   bpu_ctr_e                  ctr [1<<P_BTB_NUM];
   pc_t                       win_base;
   logic [P_BTB_NUM-1:0]      wb_idx;
   logic                      wb_bcc;
   bpu_ctr_e                  wb_ctr;

   // Lookups start at the window boundary, same as the fetched slots
   assign win_base = {fetch_pc[PC_W-1:P_FW], {P_FW{1'b0}}};

   assign wb_idx = bpu_wb.pc[P_BTB_NUM-1:0];
   assign wb_bcc = bpu_wb.valid & bpu_wb.is_bcc;

   // Step the counter seen at prediction toward the outcome
   always_comb
   begin
      wb_ctr = bpu_wb.upd.ctr;
      if (bpu_wb.taken && (bpu_wb.upd.ctr != CTR_STRONG_T))
         wb_ctr = bpu_ctr_e'(bpu_wb.upd.ctr + 2'd1);
      else if (!bpu_wb.taken && (bpu_wb.upd.ctr != CTR_STRONG_NT))
         wb_ctr = bpu_ctr_e'(bpu_wb.upd.ctr - 2'd1);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         btb_v <= '0;
         for (int i = 0; i < (1 << P_BTB_NUM); i++)
            ctr[i] <= CTR_WEAK_NT;
      end
      else if (wb_bcc)
      begin
         ctr[wb_idx] <= wb_ctr;
         if (bpu_wb.taken)
            btb_v[wb_idx] <= 1'b1;
      end
   end

   // Target only learned from taken branches
   always_ff @(posedge clk)
   begin
      if (wb_bcc && bpu_wb.taken)
      begin
         btb_tag[wb_idx] <= bpu_wb.pc[PC_W-1:P_BTB_NUM];
         btb_tgt[wb_idx] <= bpu_wb.npc_act;
      end
   end

   for (genvar j = 0; j < FW; j++)
   begin : g_slot
      pc_t                  slot_pc;
      logic [P_BTB_NUM-1:0] idx;
      logic                 hit;

      assign slot_pc = win_base + PC_W'(j);
      assign idx = slot_pc[P_BTB_NUM-1:0];
      assign hit = btb_v[idx] && (btb_tag[idx] == slot_pc[PC_W-1:P_BTB_NUM]);

      always_ff @(posedge clk or negedge arst_n)
      begin
         if (!arst_n)
         begin
            pred_upd[j].taken <= 1'b0;
            pred_upd[j].ctr <= CTR_WEAK_NT;
         end
         else if (re)
         begin
            pred_upd[j].taken <= hit && ((ctr[idx] == CTR_WEAK_T) || (ctr[idx] == CTR_STRONG_T));
            pred_upd[j].ctr <= ctr[idx];
         end
      end

      always_ff @(posedge clk)
      begin
         if (re)
            pred_npc[j] <= btb_tgt[idx];
      end
   end

endmodule

// ==== hw/fetch_ctrl.sv ====
/* Fetch control
   PC and next-PC select, window alignment and valid mask, memory address, s2 slots */

`timescale 1ns/1ps

module fetch_ctrl
(
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          flush,
   input  fetch_pkg::pc_t                flush_tgt,
   input  logic                          iq_ready,
   input  fetch_pkg::pc_t                pred_npc [fetch_pkg::FW],
   input  fetch_pkg::bpu_upd_t           pred_upd [fetch_pkg::FW],
   input  logic [fetch_pkg::VPN_W-1:0]   ppn,
   input  fetch_pkg::fetch_exc_t         exc,
   output fetch_pkg::pc_t                fetch_pc,
   output logic                          p_ce,
   output logic [fetch_pkg::AW-1:0]      imem_addr,
   input  fetch_pkg::insn_t              imem_rdata [fetch_pkg::FW],
   output fetch_pkg::fetch_slot_t        iq_slot [fetch_pkg::FW],
   output logic [fetch_pkg::P_FW:0]      iq_push_cnt
);
   import fetch_pkg::*;

   // PC of the window now in s1o
   pc_t             pc_q;
   pc_t             win_base;
   logic [P_FW-1:0] win_off;
   logic [FW-1:0]   s1i_aligned;
   logic [FW-1:0]   s1o_aligned;
   logic [FW-1:0]   s1o_valid;
   logic [P_FW:0]   s1o_cnt;
   logic            pred_taken;
   pc_t             pred_tgt;
   fetch_slot_t     s1o_slot [FW];
   fetch_slot_t     s2_slot [FW];
   logic [P_FW:0]   s2_cnt;

   // Whole pipe moves only when the queue can take a full window
   assign p_ce = iq_ready;

   always_comb
   begin
      if (flush)
         fetch_pc = flush_tgt;
      else if (!p_ce)
         fetch_pc = pc_q;
      else if (pred_taken)
         fetch_pc = pred_tgt;
      else
         fetch_pc = pc_q + PC_W'(s1o_cnt);
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         pc_q <= PC_RST[AW-1:P_INSN_LEN];
      else
         pc_q <= fetch_pc;
   end

   // A flushed window pushes nothing and gets fetched again
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         s1o_aligned <= '0;
      else if (flush)
         s1o_aligned <= '0;
      else if (p_ce)
         s1o_aligned <= s1i_aligned;
   end

   assign win_base = {pc_q[PC_W-1:P_FW], {P_FW{1'b0}}};
   assign win_off = pc_q[P_FW-1:0];

   // Slots after the first predicted-taken one are dropped
   always_comb
   begin
      pred_taken = 1'b0;
      pred_tgt = pred_npc[0];
      s1o_cnt = '0;
      for (int j = 0; j < FW; j++)
      begin
         s1o_valid[j] = s1o_aligned[j] & ~pred_taken;
         if (s1o_valid[j])
            s1o_cnt = s1o_cnt + 1'b1;
         if (s1o_valid[j] && pred_upd[j].taken)
         begin
            pred_taken = 1'b1;
            pred_tgt = pred_npc[j];
         end
      end
   end

   // Window-aligned physical byte address
   assign imem_addr = {ppn, win_base[P_PAGE-P_INSN_LEN-1:0], {P_INSN_LEN{1'b0}}};

   for (genvar k = 0; k < FW; k++)
   begin : g_slot
      logic [P_FW-1:0] src;

      assign s1i_aligned[k] = (fetch_pc[P_FW-1:0] <= P_FW'(k));

      // Pack from the first aligned slot down to position 0
      assign src = P_FW'(k) + win_off;
      assign s1o_slot[k].pc = win_base + PC_W'(src);
      assign s1o_slot[k].insn = (|exc) ? '0 : imem_rdata[src];
      assign s1o_slot[k].exc = exc;
      assign s1o_slot[k].upd = pred_upd[src];
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
         s2_slot <= s1o_slot;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         s2_cnt <= '0;
      else if (flush)
         s2_cnt <= '0;
      else if (p_ce)
         s2_cnt <= s1o_cnt;
   end

   assign iq_slot = s2_slot;
   assign iq_push_cnt = p_ce ? s2_cnt : '0;

endmodule

// ==== hw/fetch_pkg.sv ====
/* Fetch front end shared definitions
   Widths, fetch slot and writeback structs, TLB MSR bus, branch counter states */

package fetch_pkg;

   // Address and instruction widths
   localparam int AW = 32;
   localparam int P_INSN_LEN = 2;
   localparam int PC_W = AW - P_INSN_LEN;
   localparam int INSN_W = 32;

   // Fetch window
   localparam int P_FW = 1;
   localparam int FW = 1 << P_FW;

   // Paging
   localparam int P_PAGE = 13;
   localparam int VPN_W = AW - P_PAGE;
   localparam int P_TLB_SETS = 2;

   // Predictor and queue sizes
   localparam int P_BTB_NUM = 4;
   localparam int P_IQ_DEPTH = 3;

   // Byte address after reset
   localparam logic [AW-1:0] PC_RST = 32'h0000_0000;

   typedef logic [PC_W-1:0] pc_t;
   typedef logic [INSN_W-1:0] insn_t;

   // 2-bit saturating counter
   typedef enum logic [1:0]
   {
      CTR_STRONG_NT = 2'b00,
      CTR_WEAK_NT   = 2'b01,
      CTR_WEAK_T    = 2'b10,
      CTR_STRONG_T  = 2'b11
   } bpu_ctr_e;

   // Prediction info carried with each instruction down to writeback
   typedef struct packed {
      logic     taken;
      bpu_ctr_e ctr;
   } bpu_upd_t;

   typedef struct packed {
      logic itm;
      logic ipf;
   } fetch_exc_t;

   // Queue entry and decode output
   typedef struct packed {
      pc_t        pc;
      insn_t      insn;
      fetch_exc_t exc;
      bpu_upd_t   upd;
   } fetch_slot_t;

   // Branch resolution from writeback
   typedef struct packed {
      logic     valid;
      logic     is_bcc;
      logic     taken;
      pc_t      pc;
      pc_t      npc_act;
      bpu_upd_t upd;
   } bpu_wb_t;

   // TLBL/TLBH write strobes, shared index and data
   typedef struct packed {
      logic                  tlbl_we;
      logic                  tlbh_we;
      logic [P_TLB_SETS-1:0] idx;
      logic [AW-1:0]         data;
   } tlb_msr_t;

endpackage

// ==== hw/frontend.sv ====
/* Instruction fetch front end
   Predictor and TLB look up the fetch PC side by side, fetch control feeds the queue */

`timescale 1ns/1ps

module frontend
(
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          flush,
   input  fetch_pkg::pc_t                flush_tgt,
   // Decode side
   output logic [fetch_pkg::FW-1:0]      id_valid,
   output fetch_pkg::fetch_slot_t        id_slot [fetch_pkg::FW],
   input  logic [fetch_pkg::P_FW:0]      id_pop_cnt,
   // Writeback training
   input  fetch_pkg::bpu_wb_t            bpu_wb,
   // MSR
   input  logic                          psr_imme,
   input  fetch_pkg::tlb_msr_t           tlb_msr,
   // Instruction memory
   output logic [fetch_pkg::AW-1:0]      imem_addr,
   input  fetch_pkg::insn_t              imem_rdata [fetch_pkg::FW]
);
   import fetch_pkg::*;

   pc_t              fetch_pc;
   logic             p_ce;
   pc_t              pred_npc [FW];
   bpu_upd_t         pred_upd [FW];
   logic [VPN_W-1:0] ppn;
   fetch_exc_t       exc;
   fetch_slot_t      iq_slot [FW];
   logic [P_FW:0]    iq_push_cnt;
   logic             iq_ready;

   branch_predictor u_bpu
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .re       (p_ce),
      .fetch_pc (fetch_pc),
      .bpu_wb   (bpu_wb),
      .pred_npc (pred_npc),
      .pred_upd (pred_upd)
   );

   itlb u_itlb
   (
      .clk      (clk),
      .arst_n   (arst_n),
      .re       (p_ce),
      .psr_imme (psr_imme),
      .vpn      (fetch_pc[PC_W-1 -: VPN_W]),
      .tlb_msr  (tlb_msr),
      .ppn      (ppn),
      .exc      (exc)
   );

   fetch_ctrl u_fetch_ctrl
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .flush_tgt   (flush_tgt),
      .iq_ready    (iq_ready),
      .pred_npc    (pred_npc),
      .pred_upd    (pred_upd),
      .ppn         (ppn),
      .exc         (exc),
      .fetch_pc    (fetch_pc),
      .p_ce        (p_ce),
      .imem_addr   (imem_addr),
      .imem_rdata  (imem_rdata),
      .iq_slot     (iq_slot),
      .iq_push_cnt (iq_push_cnt)
   );

   insn_queue u_iq
   (
      .clk         (clk),
      .arst_n      (arst_n),
      .flush       (flush),
      .iq_slot     (iq_slot),
      .iq_push_cnt (iq_push_cnt),
      .iq_ready    (iq_ready),
      .id_valid    (id_valid),
      .id_slot     (id_slot),
      .id_pop_cnt  (id_pop_cnt)
   );

endmodule

// ==== hw/insn_queue.sv ====
/* Instruction queue
   Eight-entry ring, up to two pushes and two pops per cycle, flushable */

`timescale 1ns/1ps

module insn_queue
(
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          flush,
   input  fetch_pkg::fetch_slot_t        iq_slot [fetch_pkg::FW],
   input  logic [fetch_pkg::P_FW:0]      iq_push_cnt,
   output logic                          iq_ready,
   output logic [fetch_pkg::FW-1:0]      id_valid,
   output fetch_pkg::fetch_slot_t        id_slot [fetch_pkg::FW],
   input  logic [fetch_pkg::P_FW:0]      id_pop_cnt
);
   import fetch_pkg::*;

   fetch_slot_t           mem [1<<P_IQ_DEPTH];
   logic [P_IQ_DEPTH-1:0] head;
   logic [P_IQ_DEPTH-1:0] tail;
   logic [P_IQ_DEPTH:0]   count;
   logic [P_IQ_DEPTH:0]   free;

   assign free = (P_IQ_DEPTH+1)'(1 << P_IQ_DEPTH) - count;
   assign iq_ready = (free >= (P_IQ_DEPTH+1)'(FW));

   // Oldest entries face decode, thermometer valid
   for (genvar k = 0; k < FW; k++)
   begin : g_out
      assign id_valid[k] = (count > (P_IQ_DEPTH+1)'(k));
      assign id_slot[k] = mem[head + P_IQ_DEPTH'(k)];
   end

   always_ff @(posedge clk)
   begin
      for (int k = 0; k < FW; k++)
      begin
         if (!flush && ((P_FW+1)'(k) < iq_push_cnt))
            mem[tail + P_IQ_DEPTH'(k)] <= iq_slot[k];
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         head <= '0;
         tail <= '0;
         count <= '0;
      end
      else if (flush)
      begin
         // Drop everything, pushes included
         tail <= head;
         count <= '0;
      end
      else
      begin
         head <= head + P_IQ_DEPTH'(id_pop_cnt);
         tail <= tail + P_IQ_DEPTH'(iq_push_cnt);
         count <= count + (P_IQ_DEPTH+1)'(iq_push_cnt) - (P_IQ_DEPTH+1)'(id_pop_cnt);
      end
   end

endmodule

// ==== hw/itlb.sv ====
/* Instruction TLB
   Four direct-mapped entries written by MSR strobes, registered translation */

`timescale 1ns/1ps

module itlb
(
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          re,
   input  logic                          psr_imme,
   input  logic [fetch_pkg::VPN_W-1:0]   vpn,
   input  fetch_pkg::tlb_msr_t           tlb_msr,
   output logic [fetch_pkg::VPN_W-1:0]   ppn,
   output fetch_pkg::fetch_exc_t         exc
);
   import fetch_pkg::*;

   // TLBL fields
   logic [(1<<P_TLB_SETS)-1:0] tlbl_v;
   logic [VPN_W-1:0]           tlbl_vpn [1<<P_TLB_SETS];
   // TLBH fields
   logic [(1<<P_TLB_SETS)-1:0] tlbh_x;
   logic [VPN_W-1:0]           tlbh_ppn [1<<P_TLB_SETS];

   logic [P_TLB_SETS-1:0]      idx;
   logic                       hit;
   fetch_exc_t                 exc_nxt;
   logic [VPN_W-1:0]           ppn_nxt;

   assign idx = vpn[P_TLB_SETS-1:0];
   assign hit = tlbl_v[idx] && (tlbl_vpn[idx] == vpn);

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         tlbl_v <= '0;
      else if (tlb_msr.tlbl_we)
         tlbl_v[tlb_msr.idx] <= tlb_msr.data[0];
   end

   always_ff @(posedge clk)
   begin
      if (tlb_msr.tlbl_we)
         tlbl_vpn[tlb_msr.idx] <= tlb_msr.data[P_PAGE +: VPN_W];
      if (tlb_msr.tlbh_we)
      begin
         tlbh_x[tlb_msr.idx] <= tlb_msr.data[0];
         tlbh_ppn[tlb_msr.idx] <= tlb_msr.data[P_PAGE +: VPN_W];
      end
   end

   // Identity map while translation is off
   always_comb
   begin
      exc_nxt = '0;
      ppn_nxt = vpn;
      if (psr_imme)
      begin
         exc_nxt.itm = ~hit;
         exc_nxt.ipf = hit & ~tlbh_x[idx];
         if (hit)
            ppn_nxt = tlbh_ppn[idx];
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         exc <= '0;
      else if (re)
         exc <= exc_nxt;
   end

   always_ff @(posedge clk)
   begin
      if (re)
         ppn <= ppn_nxt;
   end

endmodule

// ==== verilog.f ====
hw/fetch_pkg.sv
hw/branch_predictor.sv
hw/itlb.sv
hw/fetch_ctrl.sv
hw/insn_queue.sv
hw/frontend.sv
bench/frontend_checker.sv
bench/frontend_tb.sv
